// ==== include/lsu_cfg.svh ====
/*
  load-store unit configuration
  data path width and the byte lane geometry that follows from it
*/

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width of the core and the memory port
`define LSU_DATA_W 32

// byte lanes per word
`define LSU_BYTES 4

// width of a byte offset inside one word, log2 of LSU_BYTES
`define LSU_OFFS_W 2

`endif

// ==== design/lsu_pkg.sv ====
/*
  core-side types of the load-store unit
  access size as seen from execute, and the controller state encoding
*/

package lsu_pkg;

  //////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////

  // byte takes the code that both byte encodings of the execute stage share
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00, // 4 bytes
    LSU_HALF = 2'b01, // 2 bytes
    LSU_BYTE = 2'b10  // single byte, never split
  } lsu_size_e;

  //////////////////////////////////////////////////
  // controller states
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    LSU_IDLE                  = 3'd0, // no address phase pending
    LSU_WAIT_GNT_MIS          = 3'd1, // first part of a split waits for grant
    LSU_WAIT_RVALID_MIS       = 3'd2, // second part requested, first response pending
    LSU_WAIT_GNT              = 3'd3, // single or second part waits for grant
    LSU_WAIT_RVALID_MIS_GNTS  = 3'd4  // both parts granted, first response pending
  } lsu_state_e;

endpackage

// ==== design/mem_bus_pkg.sv ====
/*
  memory port types
  word, byte-enable and byte-offset shapes of the data bus
*/

`include "lsu_cfg.svh"

package mem_bus_pkg;

  // one data word or one byte address
  typedef logic [`LSU_DATA_W-1:0] mem_word_t;

  // one enable per byte lane
  typedef logic [`LSU_BYTES-1:0] mem_be_t;

  // byte position inside a word
  typedef logic [`LSU_OFFS_W-1:0] mem_offs_t;

endpackage

// ==== design/lsu_ctrl.sv ====
/*
  load-store controller
  sequences request, grant and response on the memory port, splits
  misaligned accesses in two, tracks errors and the last failing address
*/

`include "lsu_cfg.svh"

module lsu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core side
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  lsu_pkg::lsu_size_e    lsu_size_i,
  input  mem_bus_pkg::mem_word_t lsu_addr_i,   // byte address
  // memory side
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  // captured write flag from the load path
  input  logic                  we_q_i,
  output logic                  data_req_o,
  output mem_bus_pkg::mem_word_t data_addr_o,  // word aligned
  output logic                  part_second_o,
  output logic                  ctrl_update_o,
  output logic                  rdata_update_o,
  output logic                  resp_valid_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output mem_bus_pkg::mem_word_t addr_last_o,
  output logic                  busy_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  lsu_state_e state_q, state_d;
  logic       mis_q, mis_d;       // high from first grant until second grant of a split
  logic       err_q, err_d;       // sticky error of the first part
  logic       split;
  logic       addr_incr;          // present the second word address
  logic       addr_update;
  logic       any_err;
  logic [1:0] outst_q;            // granted items still waiting for rvalid
  mem_offs_t  offs;
  mem_word_t  addr_word;
  mem_word_t  addr_next;
  mem_word_t  addr_last_q;

  assign offs      = lsu_addr_i[`LSU_OFFS_W-1:0];
  assign addr_word = lsu_addr_i & ~mem_word_t'(`LSU_BYTES - 1); // clear the offset bits
  assign addr_next = addr_word + mem_word_t'(`LSU_BYTES);

  // word at nonzero offset, or half straddling the word boundary
  assign split = ((lsu_size_i == LSU_WORD) && (offs != '0)) ||
                 ((lsu_size_i == LSU_HALF) && (&offs));

  //////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    mis_d          = mis_q;
    err_d          = err_q;
    data_req_o     = 1'b0;
    addr_incr      = 1'b0;
    addr_update    = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (state_q)
      LSU_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1; // first request straight from the core request
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            mis_d         = split;
            state_d       = split ? LSU_WAIT_RVALID_MIS : LSU_IDLE;
          end else begin
            state_d = split ? LSU_WAIT_GNT_MIS : LSU_WAIT_GNT;
          end
        end
      end

      LSU_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1; // byte address of the first part
          mis_d         = 1'b1;
          state_d       = LSU_WAIT_RVALID_MIS;
        end
      end

      LSU_WAIT_RVALID_MIS: begin
        data_req_o = 1'b1; // second part goes out while the first is in flight
        addr_incr  = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~lsu_we_i;  // keep upper bytes of the first word
          addr_update    = data_gnt_i & ~data_err_i;
          mis_d          = ~data_gnt_i;
          state_d        = data_gnt_i ? LSU_IDLE : LSU_WAIT_GNT;
        end else if (data_gnt_i) begin
          mis_d   = 1'b0;
          state_d = LSU_WAIT_RVALID_MIS_GNTS;
        end
      end

      LSU_WAIT_GNT: begin
        data_req_o = 1'b1;
        addr_incr  = mis_q;          // second part of a split, or a single access
        if (data_gnt_i) begin
          ctrl_update_o = ~mis_q;    // attributes are taken on the first part only
          addr_update   = ~err_q;    // keep the failing first address
          mis_d         = 1'b0;
          state_d       = LSU_IDLE;
        end
      end

      LSU_WAIT_RVALID_MIS_GNTS: begin
        addr_incr = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~lsu_we_i;
          state_d        = LSU_IDLE; // last rvalid then arrives in idle
        end
      end

      default: state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= LSU_IDLE;
      mis_q       <= 1'b0;
      err_q       <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
      if (addr_update) begin
        addr_last_q <= addr_incr ? addr_next : lsu_addr_i;
      end
    end
  end

  // outstanding count, 0 to 2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else begin
      unique case ({data_req_o & data_gnt_i, data_rvalid_i})
        2'b10:   outst_q <= outst_q + 2'd1;
        2'b01:   outst_q <= outst_q - 2'd1;
        default: outst_q <= outst_q; // none, or one in and one out
      endcase
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign data_addr_o   = addr_incr ? addr_next : addr_word;
  assign part_second_o = mis_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != LSU_IDLE);

  assign any_err      = err_q | data_err_i;              // first part or final response
  assign resp_valid_o = data_rvalid_i & (state_q == LSU_IDLE);
  assign load_err_o   = any_err & ~we_q_i & resp_valid_o;
  assign store_err_o  = any_err &  we_q_i & resp_valid_o;

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  addr_word_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[`LSU_OFFS_W-1:0] == '0));

  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {LSU_IDLE, LSU_WAIT_GNT_MIS, LSU_WAIT_RVALID_MIS, LSU_WAIT_GNT,
                    LSU_WAIT_RVALID_MIS_GNTS});

  // a response must belong to some granted request
  no_stray_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_q == LSU_IDLE) && (outst_q == '0)) |-> !data_rvalid_i);

endmodule

// ==== design/lsu_store_align.sv ====
/*
  store path alignment
  byte enables for either part of an access and write data rotated
  into its byte lanes
*/

`include "lsu_cfg.svh"

module lsu_store_align (
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  mem_bus_pkg::mem_offs_t addr_offs_i,
  input  logic                   part_second_i,  // high for the second word of a split
  input  mem_bus_pkg::mem_word_t lsu_wdata_i,
  output mem_bus_pkg::mem_be_t   data_be_o,
  output mem_bus_pkg::mem_word_t data_wdata_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  mem_be_t                     size_mask;  // enables of the access at offset 0
  logic [2*`LSU_BYTES-1:0]     be_span;    // enables across two adjacent words
  logic [2*`LSU_DATA_W-1:0]    wdata_dbl;  // doubled word for the rotation

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_size_i)
      LSU_WORD: size_mask = '1;
      LSU_HALF: size_mask = mem_be_t'(2'b11);
      default:  size_mask = mem_be_t'(1'b1); // byte
    endcase
  end

  // shift into an eight-lane window; the low half is the first word,
  // the high half is what spills into the next word
  assign be_span = {{`LSU_BYTES{1'b0}}, size_mask} << addr_offs_i;

  assign data_be_o = part_second_i ? be_span[2*`LSU_BYTES-1:`LSU_BYTES]
                                   : be_span[`LSU_BYTES-1:0];

  //////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////

  // rotate left by offset bytes, e.g. offset 1 puts byte 0 in lane 1 and
  // byte 3 in lane 0, ready for the second word
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << {addr_offs_i, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// ==== design/lsu_load_align.sv ====
/*
  load path alignment
  holds the access attributes and the first word of a split load, then
  realigns and zero- or sign-extends the response
*/

`include "lsu_cfg.svh"

module lsu_load_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,   // first part granted
  input  logic                   rdata_update_i,  // first response of a split load
  input  mem_bus_pkg::mem_offs_t addr_offs_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  logic                   lsu_we_i,
  input  mem_bus_pkg::mem_word_t data_rdata_i,
  output logic                   we_q_o,
  output mem_bus_pkg::mem_word_t rdata_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  mem_offs_t                offs_q;
  lsu_size_e                size_q;
  logic                     sign_q;
  logic                     we_q;
  logic [`LSU_DATA_W-1:8]   rdata_q;     // upper three bytes of the first word
  logic                     split_q;
  mem_word_t                rdata_join;  // split view, first word low, second word high
  mem_word_t                rdata_shift; // unsplit view, wanted byte moved to lane 0
  mem_word_t                rdata_algn;

  //////////////////////////////////////////////////
  // captured attributes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q <= '0;
      size_q <= LSU_WORD;
      sign_q <= 1'b0;
      we_q   <= 1'b0;
    end else if (ctrl_update_i) begin
      offs_q <= addr_offs_i;
      size_q <= lsu_size_i;
      sign_q <= lsu_sign_ext_i;
      we_q   <= lsu_we_i;
    end
  end

  // partial word, only meaningful during a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  assign split_q = ((size_q == LSU_WORD) && (offs_q != '0)) ||
                   ((size_q == LSU_HALF) && (&offs_q));

  always_comb begin
    unique case (offs_q)
      2'd1:    rdata_join = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_join = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    rdata_join = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_join = data_rdata_i;  // aligned word
    endcase
  end

  assign rdata_shift = data_rdata_i >> {offs_q, 3'b000};
  assign rdata_algn  = split_q ? rdata_join : rdata_shift;

  //////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////

  always_comb begin
    unique case (size_q)
      LSU_WORD: rdata_o = rdata_algn;
      LSU_HALF: rdata_o = {{(`LSU_DATA_W-16){sign_q & rdata_algn[15]}}, rdata_algn[15:0]};
      default:  rdata_o = {{(`LSU_DATA_W-8){sign_q & rdata_algn[7]}}, rdata_algn[7:0]};
    endcase
  end

  assign we_q_o = we_q; // steers error to load or store in the controller

  // the extension mux and error steering rely on known attributes
  attr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({offs_q, size_q, sign_q, we_q}));

endmodule

// ==== design/lsu_top.sv ====
/*
  load-store unit top level
  joins the controller with the store and load alignment paths between
  the execute stage and the word-aligned memory port
*/

`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core side
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  mem_bus_pkg::mem_word_t lsu_addr_i,
  input  mem_bus_pkg::mem_word_t lsu_wdata_i,
  output mem_bus_pkg::mem_word_t lsu_rdata_o,
  output logic                   lsu_rdata_valid_o,
  output logic                   lsu_resp_valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output mem_bus_pkg::mem_word_t addr_last_o,
  output logic                   busy_o,
  // memory side
  output logic                   data_req_o,
  output mem_bus_pkg::mem_word_t data_addr_o,
  output logic                   data_we_o,
  output mem_bus_pkg::mem_be_t   data_be_o,
  output mem_bus_pkg::mem_word_t data_wdata_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  mem_bus_pkg::mem_word_t data_rdata_i
);

  import mem_bus_pkg::*;

  mem_offs_t addr_offs;
  logic      part_second;
  logic      ctrl_update;
  logic      rdata_update;
  logic      we_q;

  assign addr_offs = lsu_addr_i[`LSU_OFFS_W-1:0];

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  lsu_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_addr_i     (lsu_addr_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .we_q_i         (we_q),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .part_second_o  (part_second),
    .ctrl_update_o  (ctrl_update),
    .rdata_update_o (rdata_update),
    .resp_valid_o   (lsu_resp_valid_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o),
    .addr_last_o    (addr_last_o),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // datapaths
  //////////////////////////////////////////////////

  lsu_store_align u_store_align (
    .lsu_size_i    (lsu_size_i),
    .addr_offs_i   (addr_offs),
    .part_second_i (part_second),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .addr_offs_i    (addr_offs),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_we_i       (lsu_we_i),
    .data_rdata_i   (data_rdata_i),
    .we_q_o         (we_q),
    .rdata_o        (lsu_rdata_o)
  );

  assign data_we_o = lsu_we_i; // core holds it for the whole access

  // load data only on a clean final response of a load
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~we_q & ~load_err_o;

  // enables come from the store path, the request from the controller;
  // every issued part must touch at least one byte
  be_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_be_o != '0));

endmodule

// ==== bench/tb_clk_gen.sv ====
/*
  testbench clock and reset
  100 ns clock, active-low reset held for 10 cycles
*/

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // half period
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1; // release on an edge, like any other input
  end

endmodule

// ==== bench/tb_lsu.sv ====
/*
  load-store unit testbench
  random-latency memory model, table of accesses, checks against a byte image
*/

module tb_lsu;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int RST_CYCLES = 10;
  localparam int MAX_ENTRIES = 64;

  logic clk, rst_n;
  logic lsu_req, lsu_we, lsu_sign, lsu_rdata_valid, lsu_resp_valid;
  lsu_size_e lsu_size;
  logic [31:0] lsu_addr, lsu_wdata, lsu_rdata, addr_last;
  logic load_err, store_err, busy;
  logic data_req, data_we, data_gnt, data_rvalid, data_err;
  logic [31:0] data_addr, data_wdata, data_rdata;
  logic [3:0] data_be;

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////

  logic [7:0] mem_b[64];  // memory model bytes
  logic [7:0] img[64];    // expected image, kept apart from the model
  logic [31:0] lcg_state = 32'h6d33_0f58;
  int err_count = 0, fail_tests = 0, cycle_cnt = 0, timeout_limit = 0;
  int part_idx = 0, req_count = 0, gnt_cnt = 0, last_ready = 0;
  logic [1:0] cur_errp = 2'd0;    // part that answers with an error, 0 for none
  logic [31:0] cur_addr = '0;     // byte address of the access in flight
  logic hold_pend = 1'b0;         // request seen without grant at last edge
  logic [31:0] h_addr, h_wdata;
  logic [3:0] h_be;
  logic h_we;
  logic [31:0] rsp_data_q[$];
  logic rsp_err_q[$];
  int rsp_ready_q[$];

  // stimulus table
  logic t_we[MAX_ENTRIES];
  lsu_size_e t_size[MAX_ENTRIES];
  logic [31:0] t_addr[MAX_ENTRIES], t_wdata[MAX_ENTRIES];
  logic t_sign[MAX_ENTRIES];
  logic [1:0] t_errp[MAX_ENTRIES];
  int n_entries = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  lsu_top UUT (
    .clk_i(clk), .rst_ni(rst_n),
    .lsu_req_i(lsu_req), .lsu_we_i(lsu_we), .lsu_size_i(lsu_size),
    .lsu_sign_ext_i(lsu_sign), .lsu_addr_i(lsu_addr), .lsu_wdata_i(lsu_wdata),
    .lsu_rdata_o(lsu_rdata), .lsu_rdata_valid_o(lsu_rdata_valid),
    .lsu_resp_valid_o(lsu_resp_valid), .load_err_o(load_err), .store_err_o(store_err),
    .addr_last_o(addr_last), .busy_o(busy),
    .data_req_o(data_req), .data_addr_o(data_addr), .data_we_o(data_we),
    .data_be_o(data_be), .data_wdata_o(data_wdata),
    .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid), .data_err_i(data_err),
    .data_rdata_i(data_rdata)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16]) % n;  // upper bits, better spread
  endfunction

  function automatic int size_bytes(input lsu_size_e s);
    return (s == LSU_WORD) ? 4 : ((s == LSU_HALF) ? 2 : 1);
  endfunction

  // crosses a word boundary
  function automatic logic is_split(input lsu_size_e s, input logic [31:0] a);
    return (a[1:0] + size_bytes(s) - 1) > 3;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
    err_count++;
  endtask

  task automatic add_entry(input logic we, input lsu_size_e s, input logic [31:0] a,
                           input logic [31:0] wd, input logic sg, input logic [1:0] ep);
    t_we[n_entries]    = we;
    t_size[n_entries]  = s;
    t_addr[n_entries]  = a;
    t_wdata[n_entries] = wd;
    t_sign[n_entries]  = sg;
    t_errp[n_entries]  = ep;
    n_entries++;
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [3:0] widx;
    logic [31:0] exp_word;
    logic err;
    int ready;
    cycle_cnt++;
    if (!rst_n) begin
      data_gnt    <= 1'b0;
      data_rvalid <= 1'b0;
      data_err    <= 1'b0;
      gnt_cnt     = 0;
    end else begin
      // address phase must hold while grant is low
      if (hold_pend) begin
        if (data_req !== 1'b1) report_mismatch("data_req_o", 32'd1, 32'(data_req));
        if (data_addr !== h_addr) report_mismatch("data_addr_o", h_addr, data_addr);
        if (data_be !== h_be) report_mismatch("data_be_o", 32'(h_be), 32'(data_be));
        if (data_wdata !== h_wdata) report_mismatch("data_wdata_o", h_wdata, data_wdata);
        if (data_we !== h_we) report_mismatch("data_we_o", 32'(h_we), 32'(data_we));
      end
      hold_pend = data_req && !data_gnt;
      h_addr = data_addr;
      h_be = data_be;
      h_wdata = data_wdata;
      h_we = data_we;

      if (data_req && data_gnt) begin
        part_idx++;
        req_count++;
        // word of the byte address first, the next word for a second part
        exp_word = {cur_addr[31:2], 2'b00} + 32'(4 * (part_idx - 1));
        if (data_addr !== exp_word) report_mismatch("data_addr_o", exp_word, data_addr);
        err = (cur_errp != 2'd0) && (part_idx == int'(cur_errp));
        widx = data_addr[5:2];
        if (data_we && !err) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be[b]) mem_b[{widx, 2'(b)}] = data_wdata[8*b +: 8];
          end
        end
        ready = cycle_cnt + rand_below(3);   // 1 to 3 cycles after grant
        if (ready <= last_ready) ready = last_ready + 1; // in order
        last_ready = ready;
        rsp_data_q.push_back({mem_b[{widx, 2'd3}], mem_b[{widx, 2'd2}],
                              mem_b[{widx, 2'd1}], mem_b[{widx, 2'd0}]});
        rsp_err_q.push_back(err);
        rsp_ready_q.push_back(ready);
        gnt_cnt = rand_below(4);             // 0 keeps grant up
        if (gnt_cnt != 0) data_gnt <= 1'b0;
      end else if (!data_gnt) begin
        if (gnt_cnt > 0) gnt_cnt--;
        if (gnt_cnt == 0) data_gnt <= 1'b1;
      end

      data_rvalid <= 1'b0;
      data_err    <= 1'b0;
      if (rsp_ready_q.size() > 0 && rsp_ready_q[0] <= cycle_cnt) begin
        data_rvalid <= 1'b1;
        data_rdata  <= rsp_data_q.pop_front();
        data_err    <= rsp_err_q.pop_front();
        void'(rsp_ready_q.pop_front());
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
      $display("timeout: the DUT gave no response within %0d cycles", timeout_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // one access
  //////////////////////////////////////////////////

  task automatic run_entry(input int i);
    int errs_before, n;
    logic [31:0] exp_val, exp_last, got_rdata, got_last;
    logic got_rvld, got_lerr, got_serr, ex_err;
    logic [31:0] ba;
    errs_before = err_count;
    n = size_bytes(t_size[i]);
    @(posedge clk);
    lsu_req   <= 1'b1;
    lsu_we    <= t_we[i];
    lsu_size  <= t_size[i];
    lsu_addr  <= t_addr[i];
    lsu_wdata <= t_wdata[i];
    lsu_sign  <= t_sign[i];
    cur_errp  = t_errp[i];
    cur_addr  = t_addr[i];
    part_idx  = 0;
    req_count = 0;
    @(posedge clk);
    lsu_req <= 1'b0;  // one-cycle request pulse
    do @(posedge clk); while (!lsu_resp_valid);
    got_rdata = lsu_rdata;
    got_rvld  = lsu_rdata_valid;
    got_lerr  = load_err;
    got_serr  = store_err;
    got_last  = addr_last;

    // expected values from the image
    ex_err  = (t_errp[i] != 2'd0);
    exp_val = '0;
    for (int k = 0; k < n; k++) begin
      ba = t_addr[i] + 32'(k);
      if (t_we[i]) begin
        if ((ba[31:2] == t_addr[i][31:2]) ? (t_errp[i] != 2'd1) : (t_errp[i] != 2'd2))
          img[ba[5:0]] = t_wdata[i][8*k +: 8];
      end else begin
        exp_val = exp_val | ({24'd0, img[ba[5:0]]} << (8 * k));
      end
    end
    if (n == 2 && t_sign[i] && exp_val[15]) exp_val = exp_val | 32'hffff_0000;
    if (n == 1 && t_sign[i] && exp_val[7]) exp_val = exp_val | 32'hffff_ff00;
    exp_last = t_addr[i];
    if (is_split(t_size[i], t_addr[i]) && t_errp[i] != 2'd1)
      exp_last = {t_addr[i][31:2], 2'b00} + 32'd4;  // second word

    if (req_count != (is_split(t_size[i], t_addr[i]) ? 2 : 1))
      report_mismatch("request count", is_split(t_size[i], t_addr[i]) ? 2 : 1, req_count);
    if (got_lerr !== (ex_err && !t_we[i]))
      report_mismatch("load_err_o", 32'(ex_err && !t_we[i]), 32'(got_lerr));
    if (got_serr !== (ex_err && t_we[i]))
      report_mismatch("store_err_o", 32'(ex_err && t_we[i]), 32'(got_serr));
    if (got_rvld !== (!ex_err && !t_we[i]))
      report_mismatch("lsu_rdata_valid_o", 32'(!ex_err && !t_we[i]), 32'(got_rvld));
    if (!ex_err && !t_we[i] && got_rdata !== exp_val)
      report_mismatch("lsu_rdata_o", exp_val, got_rdata);
    if (got_last !== exp_last) report_mismatch("addr_last_o", exp_last, got_last);

    if (err_count != errs_before) fail_tests++;
    $display("test %0d %s size %0d addr %h err part %0d: %s", i, t_we[i] ? "store" : "load",
             n, t_addr[i], t_errp[i], (err_count == errs_before) ? "ok" : "FAIL");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int errs_before;
    lsu_req     = 1'b0;
    lsu_we      = 1'b0;
    lsu_size    = LSU_WORD;
    lsu_sign    = 1'b0;
    lsu_addr    = '0;
    lsu_wdata   = '0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_err    = 1'b0;
    data_rdata  = '0;
    for (int a = 0; a < 64; a++) begin
      mem_b[a] = 8'(a * 29) ^ 8'h5a;  // pattern over the whole address
      img[a]   = 8'(a * 29) ^ 8'h5a;
    end

    // aligned round trip, then byte and half at every offset
    add_entry(1'b1, LSU_WORD, 32'h00, 32'hdead_beef, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h00, 32'h0, 1'b0, 2'd0);
    add_entry(1'b1, LSU_WORD, 32'h10, 32'h80ff_7f01, 1'b0, 2'd0);
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) add_entry(1'b0, LSU_BYTE, 32'h10 + 32'(o), 32'h0, s[0], 2'd0);
    end
    for (int o = 0; o < 3; o++) begin
      for (int s = 0; s < 2; s++) add_entry(1'b0, LSU_HALF, 32'h10 + 32'(o), 32'h0, s[0], 2'd0);
    end
    add_entry(1'b0, LSU_HALF, 32'h13, 32'h0, 1'b1, 2'd0);
    // split accesses
    add_entry(1'b1, LSU_WORD, 32'h21, 32'ha1b2_c3d4, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h21, 32'h0, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h20, 32'h0, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h24, 32'h0, 1'b0, 2'd0);
    add_entry(1'b1, LSU_WORD, 32'h2e, 32'h1357_9bdf, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h2e, 32'h0, 1'b0, 2'd0);
    add_entry(1'b1, LSU_HALF, 32'h37, 32'h0000_c3e1, 1'b0, 2'd0);
    add_entry(1'b0, LSU_HALF, 32'h37, 32'h0, 1'b1, 2'd0);
    add_entry(1'b0, LSU_HALF, 32'h37, 32'h0, 1'b0, 2'd0);
    add_entry(1'b1, LSU_BYTE, 32'h3a, 32'h0000_009c, 1'b0, 2'd0);
    add_entry(1'b0, LSU_BYTE, 32'h3a, 32'h0, 1'b1, 2'd0);
    // bus errors on either part
    add_entry(1'b0, LSU_WORD, 32'h05, 32'h0, 1'b0, 2'd1);
    add_entry(1'b0, LSU_WORD, 32'h05, 32'h0, 1'b0, 2'd2);
    add_entry(1'b1, LSU_WORD, 32'h0a, 32'h1122_3344, 1'b0, 2'd1);
    add_entry(1'b1, LSU_WORD, 32'h0a, 32'h5566_7788, 1'b0, 2'd2);
    add_entry(1'b0, LSU_WORD, 32'h18, 32'h0, 1'b0, 2'd1);
    add_entry(1'b1, LSU_WORD, 32'h1c, 32'hcafe_f00d, 1'b0, 2'd1);
    add_entry(1'b0, LSU_WORD, 32'h08, 32'h0, 1'b0, 2'd0);  // partial writes survive
    add_entry(1'b0, LSU_WORD, 32'h0c, 32'h0, 1'b0, 2'd0);
    add_entry(1'b0, LSU_WORD, 32'h1c, 32'h0, 1'b0, 2'd0);
    timeout_limit = n_entries * 20 + RST_CYCLES;

    wait (rst_n === 1'b1);
    errs_before = err_count;
    repeat (5) begin
      @(posedge clk);
      if (data_req !== 1'b0) report_mismatch("data_req_o", 32'd0, 32'(data_req));
      if (busy !== 1'b0) report_mismatch("busy_o", 32'd0, 32'(busy));
      if (lsu_resp_valid !== 1'b0)
        report_mismatch("lsu_resp_valid_o", 32'd0, 32'(lsu_resp_valid));
      if (lsu_rdata_valid !== 1'b0)
        report_mismatch("lsu_rdata_valid_o", 32'd0, 32'(lsu_rdata_valid));
      if ((load_err | store_err) !== 1'b0)
        report_mismatch("error outputs", 32'd0, 32'(load_err | store_err));
    end
    if (err_count != errs_before) fail_tests++;
    $display("idle after reset: %s", (err_count == errs_before) ? "ok" : "FAIL");

    for (int i = 0; i < n_entries; i++) run_entry(i);

    $display("summary: %0d tests, %0d failed, %0d errors", n_entries + 1, fail_tests, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
design/lsu_pkg.sv
design/mem_bus_pkg.sv
design/lsu_ctrl.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_top.sv
bench/tb_clk_gen.sv
bench/tb_lsu.sv

// ==== Makefile ====
# Verilator build and run of the load-store unit testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_lsu \
		--Mdir $(OBJ_DIR) -o sim_lsu
	@out="$$(./$(OBJ_DIR)/sim_lsu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
